/* rtl/cache_pkg.sv */
package cache_pkg;

    // cache geometry
    localparam int WORD_W      = 32;
    localparam int BLOCK_WORDS = 2;
    localparam int ASSOC       = 2;
    localparam int CACHE_BYTES = 1024;

    localparam int N_SETS    = CACHE_BYTES / (ASSOC * BLOCK_WORDS * (WORD_W / 8));
    localparam int SET_W     = $clog2(N_SETS);
    localparam int BLK_W     = $clog2(BLOCK_WORDS);
    localparam int TAG_W     = WORD_W - SET_W - BLK_W - 2;
    localparam int WAY_IDX_W = $clog2(ASSOC);

    // everything from here up bypasses the cache
    localparam logic [WORD_W-1:0] NONCACHE_START = 32'h8000_0000;

    // layout of one way, msb first: valid, dirty, tag, block data
    localparam int DATA_W    = BLOCK_WORDS * WORD_W;
    localparam int TAG_LSB   = DATA_W;
    localparam int DIRTY_BIT = TAG_LSB + TAG_W;
    localparam int VALID_BIT = DIRTY_BIT + 1;
    localparam int WAY_W     = VALID_BIT + 1;
    localparam int ROW_W     = ASSOC * WAY_W;    // one full set, way 0 in the low bits

    // address seen as a plain word or split into cache fields
    typedef union packed {
        logic [WORD_W-1:0] word;
        struct packed {
            logic [TAG_W-1:0] tag;
            logic [SET_W-1:0] idx;
            logic [BLK_W-1:0] blk;
            logic [1:0]       byte_off;
        } f;
    } cache_addr_u;

    typedef enum logic [2:0] {
        CLEAR,
        READY,
        FETCH,
        WRITEBACK,
        FLUSH
    } cache_state_e;

endpackage

/* rtl/cache_array.sv */
`timescale 1ns/1ps

module cache_array import cache_pkg::*; (
    input  logic             CLK,
    input  logic             nRST,
    input  logic [SET_W-1:0] set_sel,
    input  logic             wr_en,
    input  logic [ROW_W-1:0] wr_val,
    input  logic [ROW_W-1:0] wr_mask,  // a one keeps the stored bit
    output logic [ROW_W-1:0] rd_val
);

    logic [ROW_W-1:0] rows [N_SETS];
    logic [ROW_W-1:0] merged;

    // asynchronous read of the selected set
    assign rd_val = rows[set_sel];

    // only unmasked bits take the new value
    assign merged = (rd_val & wr_mask) | (wr_val & ~wr_mask);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < N_SETS; s++) begin
                rows[s] <= '0;
            end
        end else if (wr_en) begin
            rows[set_sel] <= merged;
        end
    end

endmodule

/* rtl/way_select.sv */
`timescale 1ns/1ps

module way_select import cache_pkg::*; (
    input  logic                 CLK,
    input  logic                 nRST,
    input  cache_addr_u          req_addr,
    input  logic [ROW_W-1:0]     set_rd,
    input  logic                 touch,
    input  logic [WAY_IDX_W-1:0] touch_way,
    output logic                 hit,
    output logic [WAY_IDX_W-1:0] hit_way,
    output logic [WAY_IDX_W-1:0] victim_way
);

    logic [N_SETS-1:0]    last_used;  // way used most recently, one bit per set
    logic [ASSOC-1:0]     way_valid;
    logic [ASSOC-1:0]     way_match;
    logic                 have_free;
    logic [WAY_IDX_W-1:0] free_way;

    // per-way valid and tag compare
    always_comb begin
        for (int i = 0; i < ASSOC; i++) begin
            way_valid[i] = set_rd[i*WAY_W + VALID_BIT];
            way_match[i] = way_valid[i] &&
                           (set_rd[i*WAY_W + TAG_LSB +: TAG_W] == req_addr.f.tag);
        end
    end

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int i = 0; i < ASSOC; i++) begin
            if (way_match[i]) begin
                hit     = 1'b1;
                hit_way = WAY_IDX_W'(i);
            end
        end
    end

    // an empty way gets filled before anything is evicted
    always_comb begin
        have_free = 1'b0;
        free_way  = '0;
        for (int i = ASSOC - 1; i >= 0; i--) begin
            if (!way_valid[i]) begin
                have_free = 1'b1;
                free_way  = WAY_IDX_W'(i);   // lowest empty way wins
            end
        end
    end

    // otherwise evict the way not used last
    assign victim_way = have_free ? free_way : ~last_used[req_addr.f.idx];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            last_used <= '0;
        end else if (touch) begin
            last_used[req_addr.f.idx] <= touch_way;
        end
    end

endmodule

/* rtl/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; (
    input  logic                 CLK,
    input  logic                 nRST,
    // processor side
    input  cache_addr_u          addr,
    input  logic                 ren,
    input  logic                 wen,
    input  logic [WORD_W-1:0]    wdata,
    input  logic [3:0]           byte_en,
    input  logic                 flush,
    output logic [WORD_W-1:0]    rdata,
    output logic                 busy,
    output logic                 cache_hit,
    output logic                 cache_miss,
    output logic                 flush_done,
    // array and way selection
    output logic [SET_W-1:0]     set_sel,
    output logic                 wr_en,
    output logic [ROW_W-1:0]     wr_val,
    output logic [ROW_W-1:0]     wr_mask,
    input  logic [ROW_W-1:0]     set_rd,
    input  logic                 hit,
    input  logic [WAY_IDX_W-1:0] hit_way,
    input  logic [WAY_IDX_W-1:0] victim_way,
    output logic                 touch,
    output logic [WAY_IDX_W-1:0] touch_way,
    // memory side
    output logic [WORD_W-1:0]    mem_addr,
    output logic                 mem_ren,
    output logic                 mem_wen,
    output logic [DATA_W-1:0]    mem_wdata,
    output logic [3:0]           mem_byte_en,
    input  logic [DATA_W-1:0]    mem_rdata,
    input  logic                 mem_wait
);

    cache_state_e state, next_state;

    // walk counter, set number in the upper bits and way in the lower ones
    logic [SET_W+WAY_IDX_W-1:0] cnt;
    logic [SET_W+WAY_IDX_W-1:0] cnt_inc;
    logic                       cnt_step;
    logic [SET_W-1:0]           walk_set;
    logic [WAY_IDX_W-1:0]       walk_way;

    logic flush_req;      // flush seen, walk not finished yet
    logic pass_through;

    logic [WAY_W-1:0]  hit_line;
    logic [WAY_W-1:0]  vic_line;
    logic [WAY_W-1:0]  walk_line;
    logic [WORD_W-1:0] word_keep;  // bytes a write leaves alone

    cache_addr_u fetch_addr;
    cache_addr_u wb_addr;
    cache_addr_u walk_addr;

    assign walk_way = cnt[WAY_IDX_W-1:0];
    assign walk_set = cnt[SET_W+WAY_IDX_W-1:WAY_IDX_W];

    // clear wipes a whole set per cycle, flush one way
    assign cnt_inc = (state == CLEAR) ? (SET_W + WAY_IDX_W)'(ASSOC)
                                      : (SET_W + WAY_IDX_W)'(1);

    assign pass_through = addr.word >= NONCACHE_START;

    assign hit_line  = set_rd[hit_way*WAY_W +: WAY_W];
    assign vic_line  = set_rd[victim_way*WAY_W +: WAY_W];
    assign walk_line = set_rd[walk_way*WAY_W +: WAY_W];

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            word_keep[8*b +: 8] = {8{~byte_en[b]}};
        end
    end

    // block-aligned addresses for the three kinds of block transfer
    always_comb begin
        fetch_addr            = addr;
        fetch_addr.f.blk      = '0;
        fetch_addr.f.byte_off = '0;

        wb_addr       = fetch_addr;
        wb_addr.f.tag = vic_line[TAG_LSB +: TAG_W];

        walk_addr.f.tag      = walk_line[TAG_LSB +: TAG_W];
        walk_addr.f.idx      = walk_set;
        walk_addr.f.blk      = '0;
        walk_addr.f.byte_off = '0;
    end

    always_comb begin
        next_state  = state;
        cnt_step    = 1'b0;
        busy        = 1'b1;
        rdata       = '0;
        cache_hit   = 1'b0;
        cache_miss  = 1'b0;
        flush_done  = 1'b0;
        set_sel     = addr.f.idx;
        wr_en       = 1'b0;
        wr_val      = '0;
        wr_mask     = '1;
        touch       = 1'b0;
        touch_way   = hit_way;
        mem_addr    = fetch_addr.word;
        mem_ren     = 1'b0;
        mem_wen     = 1'b0;
        mem_wdata   = '0;
        mem_byte_en = 4'hf;        // block transfers move every byte

        case (state)
            CLEAR: begin
                set_sel  = walk_set;
                wr_en    = 1'b1;
                wr_mask  = '0;
                cnt_step = 1'b1;
                if (walk_set == SET_W'(N_SETS - 1)) begin
                    next_state = READY;
                end
            end

            READY: begin
                if (flush || flush_req) begin
                    next_state = FLUSH;
                end else if (pass_through && (ren || wen)) begin
                    // straight to memory on lane 0
                    mem_addr    = addr.word;
                    mem_ren     = ren;
                    mem_wen     = wen;
                    mem_wdata   = {{(DATA_W - WORD_W){1'b0}}, wdata};
                    mem_byte_en = byte_en;
                    busy        = mem_wait;
                    rdata       = mem_rdata[WORD_W-1:0];
                end else if ((ren || wen) && hit) begin
                    busy      = 1'b0;
                    cache_hit = 1'b1;
                    touch     = 1'b1;
                    rdata     = hit_line[addr.f.blk*WORD_W +: WORD_W];
                    if (wen) begin
                        wr_en = 1'b1;
                        wr_val[hit_way*WAY_W + addr.f.blk*WORD_W +: WORD_W]  = wdata;
                        wr_mask[hit_way*WAY_W + addr.f.blk*WORD_W +: WORD_W] = word_keep;
                        wr_val[hit_way*WAY_W + DIRTY_BIT]  = 1'b1;
                        wr_mask[hit_way*WAY_W + DIRTY_BIT] = 1'b0;
                    end
                end else if (ren || wen) begin
                    // miss, dirty victim goes out first
                    if (vic_line[VALID_BIT] && vic_line[DIRTY_BIT]) begin
                        next_state = WRITEBACK;
                    end else begin
                        next_state = FETCH;
                    end
                end
            end

            WRITEBACK: begin
                mem_wen   = 1'b1;
                mem_addr  = wb_addr.word;
                mem_wdata = vic_line[DATA_W-1:0];
                if (!mem_wait) begin
                    // victim gone, drop valid and dirty
                    wr_en = 1'b1;
                    wr_mask[victim_way*WAY_W + DIRTY_BIT +: 2] = 2'b00;
                    next_state = FETCH;
                end
            end

            FETCH: begin
                mem_ren  = 1'b1;
                mem_addr = fetch_addr.word;
                if (!mem_wait) begin
                    cache_miss = 1'b1;
                    wr_en      = 1'b1;
                    wr_val[victim_way*WAY_W +: WAY_W]  = {1'b1, wen, addr.f.tag, mem_rdata};
                    wr_mask[victim_way*WAY_W +: WAY_W] = '0;
                    next_state = READY;   // request is then served as a hit
                end
            end

            FLUSH: begin
                set_sel = walk_set;
                if (walk_line[VALID_BIT] && walk_line[DIRTY_BIT]) begin
                    mem_wen   = 1'b1;
                    mem_addr  = walk_addr.word;
                    mem_wdata = walk_line[DATA_W-1:0];
                    cnt_step  = !mem_wait;
                end else begin
                    cnt_step = 1'b1;  // clean or empty way, one cycle
                end
                if (cnt_step) begin
                    wr_en = 1'b1;
                    wr_mask[walk_way*WAY_W +: WAY_W] = '0;
                    if (&cnt) begin
                        flush_done = 1'b1;
                        next_state = READY;
                    end
                end
            end

            default: begin
                next_state = CLEAR;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= CLEAR;
            cnt       <= '0;
            flush_req <= 1'b0;
        end else begin
            state <= next_state;
            if (cnt_step) begin
                cnt <= cnt + cnt_inc;   // wraps back to zero at the end of a walk
            end
            if (flush_done) begin
                flush_req <= 1'b0;
            end else if (flush) begin
                flush_req <= 1'b1;
            end
        end
    end

endmodule

/* rtl/l1_cache.sv */
`timescale 1ns/1ps

module l1_cache import cache_pkg::*; (
    input  logic                CLK,
    input  logic                nRST,
    // processor side
    input  logic [WORD_W-1:0]   addr,
    input  logic                ren,
    input  logic                wen,
    input  logic [WORD_W-1:0]   wdata,
    input  logic [3:0]          byte_en,
    input  logic                flush,
    output logic [WORD_W-1:0]   rdata,
    output logic                busy,
    output logic                cache_hit,
    output logic                cache_miss,
    output logic                flush_done,
    // memory side
    output logic [WORD_W-1:0]   mem_addr,
    output logic                mem_ren,
    output logic                mem_wen,
    output logic [DATA_W-1:0]   mem_wdata,
    output logic [3:0]          mem_byte_en,
    input  logic [DATA_W-1:0]   mem_rdata,
    input  logic                mem_wait
);

    logic [SET_W-1:0]     set_sel;
    logic                 wr_en;
    logic [ROW_W-1:0]     wr_val;
    logic [ROW_W-1:0]     wr_mask;
    logic [ROW_W-1:0]     set_rd;      // selected set, both ways
    logic                 hit;
    logic [WAY_IDX_W-1:0] hit_way;
    logic [WAY_IDX_W-1:0] victim_way;
    logic                 touch;
    logic [WAY_IDX_W-1:0] touch_way;

    cache_array i_cache_array (
        .CLK     (CLK),
        .nRST    (nRST),
        .set_sel (set_sel),
        .wr_en   (wr_en),
        .wr_val  (wr_val),
        .wr_mask (wr_mask),
        .rd_val  (set_rd)
    );

    way_select i_way_select (
        .CLK        (CLK),
        .nRST       (nRST),
        .req_addr   (addr),
        .set_rd     (set_rd),
        .touch      (touch),
        .touch_way  (touch_way),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way)
    );

    cache_ctrl i_cache_ctrl (
        .CLK         (CLK),
        .nRST        (nRST),
        .addr        (addr),
        .ren         (ren),
        .wen         (wen),
        .wdata       (wdata),
        .byte_en     (byte_en),
        .flush       (flush),
        .rdata       (rdata),
        .busy        (busy),
        .cache_hit   (cache_hit),
        .cache_miss  (cache_miss),
        .flush_done  (flush_done),
        .set_sel     (set_sel),
        .wr_en       (wr_en),
        .wr_val      (wr_val),
        .wr_mask     (wr_mask),
        .set_rd      (set_rd),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .touch       (touch),
        .touch_way   (touch_way),
        .mem_addr    (mem_addr),
        .mem_ren     (mem_ren),
        .mem_wen     (mem_wen),
        .mem_wdata   (mem_wdata),
        .mem_byte_en (mem_byte_en),
        .mem_rdata   (mem_rdata),
        .mem_wait    (mem_wait)
    );

endmodule

/* verification/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;   // 20 ns period
    end

    initial begin
        nRST = 1'b0;
        repeat (2) @(posedge CLK);
        #1 nRST = 1'b1;
    end

endmodule

/* verification/mem_model.sv */
`timescale 1ns/1ps

module mem_model import cache_pkg::*; (
    input  logic              CLK,
    input  logic              nRST,
    input  logic [WORD_W-1:0] mem_addr,
    input  logic              mem_ren,
    input  logic              mem_wen,
    input  logic [DATA_W-1:0] mem_wdata,
    input  logic [3:0]        mem_byte_en,
    output logic [DATA_W-1:0] mem_rdata,
    output logic              mem_wait
);

    logic [WORD_W-1:0] store [int unsigned];  // only words written so far
    logic [1:0]        delay;
    logic [1:0]        waited;
    int unsigned       wr_count;
    logic              req;

    // unwritten words follow the address rule
    function automatic logic [WORD_W-1:0] word_at(input logic [WORD_W-1:0] a);
        int unsigned key;
        key = int'(a[31:2]);
        if (store.exists(key)) begin
            return store[key];
        end
        return {a[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    initial begin
        void'($urandom(32'hba2f_ed25));
    end

    assign req      = mem_ren || mem_wen;
    assign mem_wait = req && (waited != delay);

    always @(mem_addr, wr_count) begin
        mem_rdata = {word_at(mem_addr + 32'd4), word_at(mem_addr)};
    end

    always @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            store.delete();
            waited   <= '0;
            delay    <= '0;
            wr_count <= 0;
        end else if (req) begin
            if (mem_wait) begin
                waited <= waited + 2'd1;
            end else begin
                waited <= '0;
                delay  <= 2'($urandom % 4);   // latency of the next transfer
                if (mem_wen) begin
                    if (mem_addr < NONCACHE_START) begin
                        store[int'(mem_addr[31:2])]       = mem_wdata[WORD_W-1:0];
                        store[int'(mem_addr[31:2]) + 1]   = mem_wdata[DATA_W-1:WORD_W];
                    end else begin
                        // pass-through, lane 0 with byte enables
                        store[int'(mem_addr[31:2])] = word_at(mem_addr);
                        for (int b = 0; b < 4; b++) begin
                            if (mem_byte_en[b]) begin
                                store[int'(mem_addr[31:2])][8*b +: 8] = mem_wdata[8*b +: 8];
                            end
                        end
                    end
                    wr_count <= wr_count + 1;
                end
            end
        end
    end

endmodule

/* verification/l1_cache_sva.sv */
`timescale 1ns/1ps

module l1_cache_sva import cache_pkg::*; (
    input logic              CLK,
    input logic              nRST,
    input logic [WORD_W-1:0] addr,
    input logic              ren,
    input logic              wen,
    input logic [WORD_W-1:0] wdata,
    input logic [3:0]        byte_en,
    input logic              busy,
    input logic              mem_ren,
    input logic              mem_wen,
    input logic [WORD_W-1:0] mem_addr
);

    // a stalled request must not change
    request_held: assert property (@(posedge CLK) disable iff (!nRST)
        (ren || wen) && busy |=> $stable(addr) && $stable(wdata) && $stable(byte_en)
                                 && $stable(ren) && $stable(wen))
        else $error("request changed while busy");

    no_read_and_write: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen))
        else $error("mem_ren and mem_wen high together");

    block_aligned: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_ren || mem_wen) && (mem_addr < NONCACHE_START) |-> (mem_addr[2:0] == 3'b000))
        else $error("cacheable memory address not block aligned");

endmodule

bind l1_cache l1_cache_sva i_l1_cache_sva (
    .CLK      (CLK),
    .nRST     (nRST),
    .addr     (addr),
    .ren      (ren),
    .wen      (wen),
    .wdata    (wdata),
    .byte_en  (byte_en),
    .busy     (busy),
    .mem_ren  (mem_ren),
    .mem_wen  (mem_wen),
    .mem_addr (mem_addr)
);

/* verification/l1_cache_tb.sv */
`timescale 1ns/1ps

module l1_cache_tb import cache_pkg::*; ();

    localparam int N_ENTRIES = 23;
    localparam int TIMEOUT   = 40 * N_ENTRIES + N_SETS;

    typedef enum {OP_RD, OP_WR, OP_FL} op_e;
    typedef enum {K_MISS, K_HIT, K_PASS, K_FLUSH} kind_e;

    typedef struct {
        op_e         op;
        logic [31:0] a;
        logic [3:0]  be;
        logic [31:0] wd;
        kind_e       kind;
        int          wbs;     // cacheable write-backs expected during the entry
    } entry_t;

    logic              CLK, nRST;
    logic [WORD_W-1:0] addr, wdata, rdata;
    logic              ren, wen, flush;
    logic [3:0]        byte_en;
    logic              busy, cache_hit, cache_miss, flush_done;
    logic [WORD_W-1:0] mem_addr;
    logic              mem_ren, mem_wen, mem_wait;
    logic [DATA_W-1:0] mem_wdata, mem_rdata;
    logic [3:0]        mem_byte_en;

    entry_t            stim [N_ENTRIES];
    logic [31:0]       shadow [int unsigned];
    int                errors;
    int                wb_count;
    int                cycles;

    tb_clock i_tb_clock (.CLK(CLK), .nRST(nRST));

    l1_cache i_l1_cache (
        .CLK(CLK), .nRST(nRST), .addr(addr), .ren(ren), .wen(wen), .wdata(wdata),
        .byte_en(byte_en), .flush(flush), .rdata(rdata), .busy(busy),
        .cache_hit(cache_hit), .cache_miss(cache_miss), .flush_done(flush_done),
        .mem_addr(mem_addr), .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_wdata(mem_wdata),
        .mem_byte_en(mem_byte_en), .mem_rdata(mem_rdata), .mem_wait(mem_wait)
    );

    mem_model i_mem_model (
        .CLK(CLK), .nRST(nRST), .mem_addr(mem_addr), .mem_ren(mem_ren),
        .mem_wen(mem_wen), .mem_wdata(mem_wdata), .mem_byte_en(mem_byte_en),
        .mem_rdata(mem_rdata), .mem_wait(mem_wait)
    );

    function automatic logic [31:0] shadow_word(input logic [31:0] a);
        if (shadow.exists(int'(a[31:2]))) begin
            return shadow[int'(a[31:2])];
        end
        return {a[31:2], 2'b00} ^ 32'h5a5a_0000;   // reset contents of memory
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  be);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic add_entry(input int i, input op_e op, input logic [31:0] a,
                             input logic [3:0] be, input logic [31:0] wd,
                             input kind_e kind, input int wbs);
        stim[i] = '{op, a, be, wd, kind, wbs};
    endtask

    // set 8 blocks are 0x040, 0x240, 0x440, one set apart by 0x200
    task automatic fill_table();
        add_entry(0,  OP_RD, 32'h0000_0100, 4'hf, 32'h0,         K_MISS,  0);
        add_entry(1,  OP_RD, 32'h0000_0104, 4'hf, 32'h0,         K_HIT,   0);
        add_entry(2,  OP_RD, 32'h0000_0100, 4'hf, 32'h0,         K_HIT,   0);
        add_entry(3,  OP_RD, 32'h0000_0040, 4'hf, 32'h0,         K_MISS,  0);
        add_entry(4,  OP_WR, 32'h0000_0040, 4'h1, 32'h1122_3344, K_HIT,   0);
        add_entry(5,  OP_WR, 32'h0000_0040, 4'h3, 32'haabb_ccdd, K_HIT,   0);
        add_entry(6,  OP_WR, 32'h0000_0044, 4'hc, 32'h9988_7766, K_HIT,   0);
        add_entry(7,  OP_RD, 32'h0000_0040, 4'hf, 32'h0,         K_HIT,   0);
        add_entry(8,  OP_RD, 32'h0000_0044, 4'hf, 32'h0,         K_HIT,   0);
        add_entry(9,  OP_WR, 32'h0000_0048, 4'hf, 32'hdead_beef, K_MISS,  0);
        add_entry(10, OP_RD, 32'h0000_0240, 4'hf, 32'h0,         K_MISS,  0);
        add_entry(11, OP_RD, 32'h0000_0440, 4'hf, 32'h0,         K_MISS,  1);
        add_entry(12, OP_RD, 32'h0000_0040, 4'hf, 32'h0,         K_MISS,  0);
        add_entry(13, OP_WR, 32'h0000_0104, 4'h2, 32'h0000_ab00, K_HIT,   0);
        add_entry(14, OP_FL, 32'h0,         4'h0, 32'h0,         K_FLUSH, 2);
        add_entry(15, OP_RD, 32'h0000_0048, 4'hf, 32'h0,         K_MISS,  0);
        add_entry(16, OP_RD, 32'h0000_0104, 4'hf, 32'h0,         K_MISS,  0);
        add_entry(17, OP_RD, 32'h0000_0040, 4'hf, 32'h0,         K_MISS,  0);
        add_entry(18, OP_WR, 32'h8000_0010, 4'h3, 32'h1234_5678, K_PASS,  0);
        add_entry(19, OP_RD, 32'h8000_0010, 4'hf, 32'h0,         K_PASS,  0);
        add_entry(20, OP_WR, 32'h8000_0010, 4'h8, 32'hcafe_f00d, K_PASS,  0);
        add_entry(21, OP_RD, 32'h8000_0010, 4'hf, 32'h0,         K_PASS,  0);
        add_entry(22, OP_RD, 32'h8000_0014, 4'hf, 32'h0,         K_PASS,  0);
    endtask

    // every cacheable block written out must match the shadow copy
    always @(negedge CLK) begin
        if (nRST && mem_wen && !mem_wait && mem_addr < NONCACHE_START) begin
            wb_count++;
            if (mem_wdata !== {shadow_word(mem_addr + 32'd4), shadow_word(mem_addr)}) begin
                $display("[ERROR] mem_wdata at %h: got %h, expected %h", mem_addr, mem_wdata,
                         {shadow_word(mem_addr + 32'd4), shadow_word(mem_addr)});
                errors++;
            end
            if (mem_byte_en !== 4'hf) begin
                $display("[ERROR] mem_byte_en: got %h, expected f", mem_byte_en);
                errors++;
            end
        end
    end

    task automatic apply_entry(input int i);
        entry_t      e;
        int          cyc;
        int          wb_start;
        logic        done;
        logic        seen_hit;
        logic        seen_miss;
        logic        seen_mem;
        logic        seen_ren;
        logic        seen_wen;
        logic [3:0]  seen_be;
        logic [31:0] got;
        e         = stim[i];
        wb_start  = wb_count;
        cyc       = 0;
        done      = 1'b0;
        seen_hit  = 1'b0;
        seen_miss = 1'b0;
        seen_mem  = 1'b0;
        seen_ren  = 1'b0;
        seen_wen  = 1'b0;
        seen_be   = '0;
        got       = '0;
        if (e.op == OP_FL) begin
            flush = 1'b1;
            @(posedge CLK);
            #1 flush = 1'b0;
            do @(negedge CLK); while (!flush_done);
            @(posedge CLK);
            #1;
        end else begin
            addr    = e.a;
            byte_en = e.be;
            wdata   = e.wd;
            ren     = (e.op == OP_RD);
            wen     = (e.op == OP_WR);
            while (!done) begin
                @(negedge CLK);
                cyc++;
                seen_hit  = seen_hit | cache_hit;
                seen_miss = seen_miss | cache_miss;
                seen_ren  = seen_ren | mem_ren;
                seen_wen  = seen_wen | mem_wen;
                if (mem_ren || mem_wen) begin
                    seen_mem = 1'b1;
                    seen_be  = mem_byte_en;
                end
                if (!busy) begin
                    done = 1'b1;
                    got  = rdata;
                end
            end
            @(posedge CLK);
            #1 ren = 1'b0;
            wen = 1'b0;
            if (i == 0 && cyc < N_SETS) begin
                $display("entry 0 finished after %0d cycles, before the clear ended", cyc);
                errors++;
            end
            if (e.kind == K_MISS && !seen_miss) begin
                $display("entry %0d: miss at %h did not pulse cache_miss", i, e.a);
                errors++;
            end
            if (e.kind == K_MISS && !seen_ren) begin
                $display("entry %0d: miss at %h never raised mem_ren for the fetch", i, e.a);
                errors++;
            end
            if (e.kind == K_HIT && (!seen_hit || seen_miss || seen_mem || cyc != 1)) begin
                $display("entry %0d: access at %h was not served as a hit", i, e.a);
                errors++;
            end
            if (e.kind == K_PASS) begin
                if (!seen_mem || seen_hit) begin
                    $display("entry %0d: pass-through at %h did not go to memory", i, e.a);
                    errors++;
                end else if (seen_ren != (e.op == OP_RD) || seen_wen != (e.op == OP_WR)) begin
                    $display("entry %0d: pass-through at %h used the wrong memory strobe",
                             i, e.a);
                    errors++;
                end else if (seen_be !== e.be) begin
                    $display("[ERROR] mem_byte_en: got %h, expected %h", seen_be, e.be);
                    errors++;
                end
            end
            if (e.op == OP_WR) begin
                shadow[int'(e.a[31:2])] = merge_bytes(shadow_word(e.a), e.wd, e.be);
            end else if (got !== shadow_word(e.a)) begin
                $display("[ERROR] rdata at %h: got %h, expected %h", e.a, got,
                         shadow_word(e.a));
                errors++;
            end
        end
        if (wb_count - wb_start != e.wbs) begin
            $display("[ERROR] write-back count in entry %0d: got %h, expected %h", i,
                     wb_count - wb_start, e.wbs);
            errors++;
        end
    endtask

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, the cache stopped responding", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        errors   = 0;
        wb_count = 0;
        cycles   = 0;
        addr     = '0;
        wdata    = '0;
        byte_en  = '0;
        ren      = 1'b0;
        wen      = 1'b0;
        flush    = 1'b0;
        fill_table();
        wait (nRST);
        @(posedge CLK);
        #1;
        for (int i = 0; i < N_ENTRIES; i++) begin
            apply_entry(i);
        end
        $display("run complete, %0d errors", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* filelist.f */
rtl/cache_pkg.sv
rtl/cache_array.sv
rtl/way_select.sv
rtl/cache_ctrl.sv
rtl/l1_cache.sv
verification/tb_clock.sv
verification/mem_model.sv
verification/l1_cache_sva.sv
verification/l1_cache_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module l1_cache_tb -f filelist.f -o l1_cache_sim

out=$(./obj_dir/l1_cache_sim)
echo "$out"

if echo "$out" | grep -q "^NO ERRORS$"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
